//--- boss_sprite.hex
// boss sprite, 8 rows of 8 twelve-bit rgb pixels, row-major from the top-left corner.
// f00 is the key colour and lets the background through.
F00 F00 A50 A50 A50 A50 F00 F00
F00 A50 FF0 A50 A50 FF0 A50 F00
A50 A50 000 A50 A50 000 A50 A50
A50 A50 A50 A50 A50 A50 A50 A50
A50 C00 C00 C00 C00 C00 C00 A50
A50 A50 FFF A50 A50 FFF A50 A50
F00 A50 A50 A50 A50 A50 A50 F00
F00 F00 A50 F00 F00 A50 F00 F00

//--- run_sim.sh
#!/usr/bin/env bash
# builds the overlay testbench with verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_game_render -o tb_game_render \
    && ./obj_dir/tb_game_render > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "TESTBENCH PASSED" "$LOG" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sources.f
src/vga_pkg.sv
src/vga_timing.sv
src/game_regs.sv
src/boss_render.sv
src/hp_bar_render.sv
src/game_render_top.sv
tb/tb_game_render.sv

//--- src/boss_render.sv
// boss sprite overlay stage, paints the 8x8 boss from rom over the pixel stream.
`timescale 1ns/1ps
`default_nettype none

module boss_render (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::game_state_e game_state,
    input  vga_pkg::coord_t      boss_x,
    input  vga_pkg::coord_t      boss_y,
    input  vga_pkg::hp_t         boss_hp,
    input  vga_pkg::coord_t      hcount_in,
    input  vga_pkg::coord_t      vcount_in,
    input  logic                 hsync_in,
    input  logic                 vsync_in,
    input  logic                 blank_in,
    input  vga_pkg::rgb_t        rgb_in,
    output vga_pkg::coord_t      hcount_out,
    output vga_pkg::coord_t      vcount_out,
    output logic                 hsync_out,
    output logic                 vsync_out,
    output logic                 blank_out,
    output vga_pkg::rgb_t        rgb_out,
    output logic                 boss_alive
);

    localparam int ROM_DEPTH = vga_pkg::SPRITE_W * vga_pkg::SPRITE_H;
    localparam int ROM_AW    = $clog2(ROM_DEPTH);

    vga_pkg::rgb_t   boss_rom [0:ROM_DEPTH-1];
    vga_pkg::coord_t rel_x;
    vga_pkg::coord_t rel_y;
    vga_pkg::coord_t rom_idx;
    vga_pkg::rgb_t   rom_pix;
    vga_pkg::rgb_t   rgb_nxt;
    logic            in_box;
    logic            alive_nxt;

    initial $readmemh("boss_sprite.hex", boss_rom);

    // position relative to the top-left corner of the box.
    // sprite is centred, so the corner is 4 back on each axis.
    assign rel_x   = hcount_in - boss_x + vga_pkg::coord_t'(vga_pkg::SPRITE_W / 2);
    assign rel_y   = vcount_in - boss_y + vga_pkg::coord_t'(vga_pkg::SPRITE_H / 2);
    assign in_box  = (rel_x < vga_pkg::coord_t'(vga_pkg::SPRITE_W)) &&
                     (rel_y < vga_pkg::coord_t'(vga_pkg::SPRITE_H));
    // row-major rom index.
    assign rom_idx = vga_pkg::coord_t'(rel_y * vga_pkg::SPRITE_W + rel_x);
    assign rom_pix = boss_rom[rom_idx[ROM_AW-1:0]];

    // alive only while playing with hit points left.
    assign alive_nxt = (game_state == vga_pkg::GAME_PLAY) && (boss_hp != '0);

    always_comb begin
        rgb_nxt = rgb_in;
        // key colour lets the background through.
        if (alive_nxt && !blank_in && in_box && (rom_pix != vga_pkg::KEY_COLOR)) begin
            rgb_nxt = rom_pix;
        end
    end

    // one stage of delay on the whole stream.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            blank_out  <= 1'b1;
            boss_alive <= 1'b0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            blank_out  <= blank_in;
            boss_alive <= alive_nxt;
        end
    end

    // pixel colour.
    always_ff @(posedge clk) begin
        rgb_out <= rgb_nxt;
    end

    // box decode must map into the sprite rom.
    assert property (@(posedge clk) disable iff (!rst_n)
        in_box |-> (rom_idx < vga_pkg::coord_t'(ROM_DEPTH)))
        else $error("sprite rom index %0d out of range", rom_idx);

endmodule

`default_nettype wire

//--- src/game_regs.sv
// wishbone classic slave holding the game state and boss registers.
`timescale 1ns/1ps
`default_nettype none

module game_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [2:0]            adr,
    input  logic [15:0]           dat_w,
    output logic [15:0]           dat_r,
    output logic                  ack,
    output vga_pkg::game_state_e  game_state,
    output vga_pkg::coord_t       boss_x,
    output vga_pkg::coord_t       boss_y,
    output vga_pkg::hp_t          boss_hp,
    output vga_pkg::rgb_t         bg_color
);

    logic        req;
    logic [15:0] rd_data;

    // new transfer seen, ack not yet given.
    assign req = cyc && stb && !ack;

    // read mux, zero extended.
    always_comb begin
        case (adr)
            vga_pkg::REG_STATE:   rd_data = 16'(game_state);
            vga_pkg::REG_BOSS_X:  rd_data = 16'(boss_x);
            vga_pkg::REG_BOSS_Y:  rd_data = 16'(boss_y);
            vga_pkg::REG_BOSS_HP: rd_data = 16'(boss_hp);
            vga_pkg::REG_BG:      rd_data = 16'(bg_color);
            default:              rd_data = '0;
        endcase
    end

    // writes land on the edge that raises ack.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            game_state <= vga_pkg::GAME_MENU;
            boss_x     <= '0;
            boss_y     <= '0;
            boss_hp    <= '0;
            bg_color   <= '0;
        end else begin
            ack <= req;
            if (req && we) begin
                case (adr)
                    vga_pkg::REG_STATE:   game_state <= vga_pkg::game_state_e'(dat_w[1:0]);
                    vga_pkg::REG_BOSS_X:  boss_x     <= dat_w[10:0];
                    vga_pkg::REG_BOSS_Y:  boss_y     <= dat_w[10:0];
                    // clip to a full bar.
                    vga_pkg::REG_BOSS_HP: boss_hp    <= (dat_w > 16'(vga_pkg::HP_MAX)) ?
                                                        vga_pkg::hp_t'(vga_pkg::HP_MAX) :
                                                        dat_w[6:0];
                    vga_pkg::REG_BG:      bg_color   <= dat_w[11:0];
                    default:              ;
                endcase
            end
        end
    end

    // read data goes out with ack.
    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= rd_data;
        end
    end

    // single-cycle ack, even with stb still held.
    assert property (@(posedge clk) disable iff (!rst_n)
        (ack && stb) |=> !ack)
        else $error("ack held for two cycles");

endmodule

`default_nettype wire

//--- src/game_render_top.sv
// game overlay top, registers, timing, background fill and two render stages.
`timescale 1ns/1ps
`default_nettype none

module game_render_top #(
    parameter int H_ACTIVE     = 800,
    parameter int H_TOTAL      = 1056,
    parameter int H_SYNC_START = 840,
    parameter int H_SYNC_END   = 968,
    parameter int V_ACTIVE     = 600,
    parameter int V_TOTAL      = 628,
    parameter int V_SYNC_START = 601,
    parameter int V_SYNC_END   = 605
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  logic [2:0]      adr,
    input  logic [15:0]     dat_w,
    output logic [15:0]     dat_r,
    output logic            ack,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            blank,
    output vga_pkg::rgb_t   rgb,
    output logic            boss_alive
);

    vga_pkg::game_state_e game_state;
    vga_pkg::coord_t      boss_x;
    vga_pkg::coord_t      boss_y;
    vga_pkg::hp_t         boss_hp;
    vga_pkg::rgb_t        bg_color;

    // raw timing stream.
    vga_pkg::coord_t      t_hcount;
    vga_pkg::coord_t      t_vcount;
    logic                 t_hsync;
    logic                 t_vsync;
    logic                 t_blank;
    vga_pkg::rgb_t        t_rgb;

    // stream after the boss stage.
    vga_pkg::coord_t      s1_hcount;
    vga_pkg::coord_t      s1_vcount;
    logic                 s1_hsync;
    logic                 s1_vsync;
    logic                 s1_blank;
    vga_pkg::rgb_t        s1_rgb;

    game_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .game_state (game_state),
        .boss_x     (boss_x),
        .boss_y     (boss_y),
        .boss_hp    (boss_hp),
        .bg_color   (bg_color)
    );

    vga_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) u_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .hcount (t_hcount),
        .vcount (t_vcount),
        .hsync  (t_hsync),
        .vsync  (t_vsync),
        .blank  (t_blank)
    );

    // background, black in blanking.
    // stages only draw on visible pixels, so this holds to the output.
    assign t_rgb = t_blank ? vga_pkg::rgb_t'(0) : bg_color;

    boss_render u_boss (
        .clk        (clk),
        .rst_n      (rst_n),
        .game_state (game_state),
        .boss_x     (boss_x),
        .boss_y     (boss_y),
        .boss_hp    (boss_hp),
        .hcount_in  (t_hcount),
        .vcount_in  (t_vcount),
        .hsync_in   (t_hsync),
        .vsync_in   (t_vsync),
        .blank_in   (t_blank),
        .rgb_in     (t_rgb),
        .hcount_out (s1_hcount),
        .vcount_out (s1_vcount),
        .hsync_out  (s1_hsync),
        .vsync_out  (s1_vsync),
        .blank_out  (s1_blank),
        .rgb_out    (s1_rgb),
        .boss_alive (boss_alive)
    );

    // registered alive flag lines up with the stage 1 pixel.
    hp_bar_render u_hp_bar (
        .clk        (clk),
        .rst_n      (rst_n),
        .boss_hp    (boss_hp),
        .boss_alive (boss_alive),
        .hcount_in  (s1_hcount),
        .vcount_in  (s1_vcount),
        .hsync_in   (s1_hsync),
        .vsync_in   (s1_vsync),
        .blank_in   (s1_blank),
        .rgb_in     (s1_rgb),
        .hcount_out (hcount),
        .vcount_out (vcount),
        .hsync_out  (hsync),
        .vsync_out  (vsync),
        .blank_out  (blank),
        .rgb_out    (rgb)
    );

endmodule

`default_nettype wire

//--- src/hp_bar_render.sv
// hit-point bar overlay stage, paints the boss bar near the top of the frame.
`timescale 1ns/1ps
`default_nettype none

module hp_bar_render (
    input  logic            clk,
    input  logic            rst_n,
    input  vga_pkg::hp_t    boss_hp,
    input  logic            boss_alive,
    input  vga_pkg::coord_t hcount_in,
    input  vga_pkg::coord_t vcount_in,
    input  logic            hsync_in,
    input  logic            vsync_in,
    input  logic            blank_in,
    input  vga_pkg::rgb_t   rgb_in,
    output vga_pkg::coord_t hcount_out,
    output vga_pkg::coord_t vcount_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            blank_out,
    output vga_pkg::rgb_t   rgb_out
);

    vga_pkg::coord_t bar_col;
    logic            in_rows;
    logic            in_cols;
    vga_pkg::rgb_t   rgb_nxt;

    // column within the bar, wraps high left of BAR_X.
    assign bar_col = hcount_in - vga_pkg::coord_t'(vga_pkg::BAR_X);
    assign in_rows = (vcount_in >= vga_pkg::coord_t'(vga_pkg::BAR_Y0)) &&
                     (vcount_in <= vga_pkg::coord_t'(vga_pkg::BAR_Y1));
    assign in_cols = (hcount_in >= vga_pkg::coord_t'(vga_pkg::BAR_X)) &&
                     (bar_col < vga_pkg::coord_t'(vga_pkg::HP_MAX));

    always_comb begin
        rgb_nxt = rgb_in;
        // bar sits on top of the boss.
        if (boss_alive && !blank_in && in_rows && in_cols) begin
            if (bar_col < vga_pkg::coord_t'(boss_hp)) begin
                rgb_nxt = vga_pkg::BAR_FULL;
            end else begin
                rgb_nxt = vga_pkg::BAR_EMPTY;
            end
        end
    end

    // second stage of delay.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            blank_out  <= 1'b1;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            blank_out  <= blank_in;
        end
    end

    always_ff @(posedge clk) begin
        rgb_out <= rgb_nxt;
    end

endmodule

`default_nettype wire

//--- src/vga_pkg.sv
// shared video and game definitions for the overlay renderer.
`default_nettype none

package vga_pkg;

    // 4:4:4 colour.
    typedef logic [11:0] rgb_t;
    // screen coordinate and boss position.
    typedef logic [10:0] coord_t;
    // boss hit points.
    typedef logic [6:0] hp_t;

    // 1 means a game in progress.
    typedef enum logic [1:0] {
        GAME_MENU = 2'd0,
        GAME_PLAY = 2'd1,
        GAME_OVER = 2'd2
    } game_state_e;

    // sprite geometry and transparency.
    localparam rgb_t KEY_COLOR = 12'hF00;
    localparam int   SPRITE_W  = 8;
    localparam int   SPRITE_H  = 8;

    // hit-point bar placement and colours.
    localparam int   HP_MAX    = 64;
    localparam int   BAR_X     = 4;
    localparam int   BAR_Y0    = 2;
    localparam int   BAR_Y1    = 5;
    localparam rgb_t BAR_FULL  = 12'h0F0;
    localparam rgb_t BAR_EMPTY = 12'h333;

    // wishbone word addresses.
    localparam logic [2:0] REG_STATE   = 3'd0;
    localparam logic [2:0] REG_BOSS_X  = 3'd1;
    localparam logic [2:0] REG_BOSS_Y  = 3'd2;
    localparam logic [2:0] REG_BOSS_HP = 3'd3;
    localparam logic [2:0] REG_BG      = 3'd4;

endpackage

`default_nettype wire

//--- src/vga_timing.sv
// vga timing generator, scans a parameterised frame with sync and blanking.
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE     = 800,
    parameter int H_TOTAL      = 1056,
    parameter int H_SYNC_START = 840,
    parameter int H_SYNC_END   = 968,
    parameter int V_ACTIVE     = 600,
    parameter int V_TOTAL      = 628,
    parameter int V_SYNC_START = 601,
    parameter int V_SYNC_END   = 605
) (
    input  logic            clk,
    input  logic            rst_n,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            blank
);

    vga_pkg::coord_t h_nxt;
    vga_pkg::coord_t v_nxt;

    // next position, line wrap then frame wrap.
    always_comb begin
        h_nxt = hcount + 1'b1;
        v_nxt = vcount;
        if (hcount == vga_pkg::coord_t'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (vcount == vga_pkg::coord_t'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vcount + 1'b1;
            end
        end
    end

    // sync and blank decoded from the next position.
    // so they line up with the registered counters.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            blank  <= 1'b1;
        end else begin
            hcount <= h_nxt;
            vcount <= v_nxt;
            hsync  <= (h_nxt >= vga_pkg::coord_t'(H_SYNC_START)) &&
                      (h_nxt <  vga_pkg::coord_t'(H_SYNC_END));
            vsync  <= (v_nxt >= vga_pkg::coord_t'(V_SYNC_START)) &&
                      (v_nxt <  vga_pkg::coord_t'(V_SYNC_END));
            blank  <= (h_nxt >= vga_pkg::coord_t'(H_ACTIVE)) ||
                      (v_nxt >= vga_pkg::coord_t'(V_ACTIVE));
        end
    end

    // line counter stays inside the frame.
    assert property (@(posedge clk) disable iff (!rst_n)
        hcount < vga_pkg::coord_t'(H_TOTAL))
        else $error("hcount %0d beyond line length", hcount);

endmodule

`default_nettype wire

//--- tb/tb_game_render.sv
// self-checking testbench for the game overlay renderer on a tiny frame.
`timescale 1ns/1ps
`default_nettype none

module tb_game_render;

    // 40x30 visible inside a 50x36 frame.
    localparam int H_ACTIVE     = 40;
    localparam int H_TOTAL      = 50;
    localparam int H_SYNC_START = 42;
    localparam int H_SYNC_END   = 46;
    localparam int V_ACTIVE     = 30;
    localparam int V_TOTAL      = 36;
    localparam int V_SYNC_START = 31;
    localparam int V_SYNC_END   = 33;

    localparam int FRAME       = H_TOTAL * V_TOTAL;
    localparam int BUS_TIMEOUT = 16;
    localparam int PIX_TIMEOUT = 2 * FRAME;
    // half size of the probe window around a sprite.
    localparam int WIN         = 7;
    // background column value that asks for a random colour.
    localparam int RAND_BG     = -1;

    localparam int MENU = int'(vga_pkg::GAME_MENU);
    localparam int PLAY = int'(vga_pkg::GAME_PLAY);
    localparam int OVER = int'(vga_pkg::GAME_OVER);

    // table columns.
    localparam int C_STATE  = 0;
    localparam int C_BX     = 1;
    localparam int C_BY     = 2;
    localparam int C_HP     = 3;
    localparam int C_BG     = 4;
    localparam int C_PX     = 5;
    localparam int C_PY     = 6;
    localparam int C_ALIVE  = 7;
    localparam int NUM_ROWS = 9;

    // state, boss x, boss y, hp, background, probe x, probe y, alive.
    localparam int STIM [NUM_ROWS][8] = '{
        '{PLAY, 20, 15,  40, 'h123,   20, 15, 1},
        '{PLAY,  4,  4,  13, RAND_BG,  4,  4, 1},
        '{PLAY, 36, 26,   1, 'h00F,   36, 26, 1},
        '{PLAY, 30, 10,  64, RAND_BG, 30, 10, 1},
        '{MENU, 20, 15,  40, 'h456,   20, 15, 0},
        '{OVER, 20, 15,  40, RAND_BG, 20, 15, 0},
        '{PLAY, 20, 15,   0, 'h789,   20, 15, 0},
        '{PLAY, 39, 29, 100, RAND_BG, 39, 29, 1},
        '{PLAY,  0,  0,   7, 'h0A0,    0,  0, 1}
    };

    logic            clk;
    logic            rst_n;
    logic            cyc;
    logic            stb;
    logic            we;
    logic [2:0]      adr;
    logic [15:0]     dat_w;
    logic [15:0]     dat_r;
    logic            ack;
    vga_pkg::coord_t hcount;
    vga_pkg::coord_t vcount;
    logic            hsync;
    logic            vsync;
    logic            blank;
    vga_pkg::rgb_t   rgb;
    logic            boss_alive;

    logic [11:0]     sprite [0:63];
    logic [16:0]     lfsr_state;

    game_render_top #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .blank      (blank),
        .rgb        (rgb),
        .boss_alive (boss_alive)
    );

    // 20 ns pixel clock.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "wait timed out");
    endtask

    // outputs settled, inputs may change.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // 17-bit fibonacci lfsr, taps 17 and 14.
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one lfsr step per bit taken.
    task automatic draw_bits(input int n, output logic [15:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            val        = {val[14:0], lfsr_state[16]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic wb_write(input logic [2:0] a, input logic [15:0] d);
        int n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = a;
        dat_w = d;
        n     = 0;
        next_cycle();
        while (!ack) begin
            n++;
            if (n > BUS_TIMEOUT) timeout_abort("ack on a wishbone write");
            next_cycle();
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] a, output logic [15:0] d);
        int n;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        n   = 0;
        next_cycle();
        while (!ack) begin
            n++;
            if (n > BUS_TIMEOUT) timeout_abort("ack on a wishbone read");
            next_cycle();
        end
        d   = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    // next time the output pixel is at the target.
    task automatic wait_pixel(input int tx, input int ty);
        int n;
        n = 0;
        next_cycle();
        while (!(hcount == vga_pkg::coord_t'(tx) && vcount == vga_pkg::coord_t'(ty))) begin
            n++;
            if (n > PIX_TIMEOUT) timeout_abort("an output pixel position");
            next_cycle();
        end
    endtask

    // colour of one output pixel for a table row.
    function automatic logic [11:0] expected_rgb(input int r, input int x, input int y,
                                                 input logic [11:0] bg);
        int          hp;
        int          sx;
        int          sy;
        logic        alive;
        logic [11:0] c;
        hp    = (STIM[r][C_HP] > vga_pkg::HP_MAX) ? vga_pkg::HP_MAX : STIM[r][C_HP];
        alive = (STIM[r][C_STATE] == PLAY) && (hp != 0);
        if (x >= H_ACTIVE || y >= V_ACTIVE) return 12'h000;
        c = bg;
        if (alive) begin
            // sprite box is centred on the boss.
            sx = x - STIM[r][C_BX] + vga_pkg::SPRITE_W / 2;
            sy = y - STIM[r][C_BY] + vga_pkg::SPRITE_H / 2;
            if (sx >= 0 && sx < vga_pkg::SPRITE_W && sy >= 0 && sy < vga_pkg::SPRITE_H) begin
                if (sprite[sy * vga_pkg::SPRITE_W + sx] != vga_pkg::KEY_COLOR)
                    c = sprite[sy * vga_pkg::SPRITE_W + sx];
            end
            // bar is painted last, over the boss.
            if (y >= vga_pkg::BAR_Y0 && y <= vga_pkg::BAR_Y1 &&
                x >= vga_pkg::BAR_X && x < vga_pkg::BAR_X + vga_pkg::HP_MAX) begin
                c = (x - vga_pkg::BAR_X < hp) ? vga_pkg::BAR_FULL : vga_pkg::BAR_EMPTY;
            end
        end
        return c;
    endfunction

    initial begin : stimulus
        logic [15:0] rd;
        logic [15:0] bits;
        logic [11:0] bg;
        int          cx;
        int          cy;
        int          x;
        int          y;
        int          k;
        int          r;

        rst_n      = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        lfsr_state = 17'd91203;
        $readmemh("boss_sprite.hex", sprite);

        // reset state.
        repeat (8) @(posedge clk);
        #2;
        check("ack", 0, ack);
        check("boss_alive", 0, boss_alive);
        check("blank", 1, blank);
        rst_n = 1'b1;

        // register reset values, then write and read back.
        for (k = 0; k < 5; k++) begin
            wb_read(3'(k), rd);
            check("reset dat_r", 0, rd);
        end
        wb_write(vga_pkg::REG_STATE, 16'd2);
        wb_read(vga_pkg::REG_STATE, rd);
        check("state dat_r", 2, rd);
        wb_write(vga_pkg::REG_BOSS_X, 16'h123);
        wb_read(vga_pkg::REG_BOSS_X, rd);
        check("boss_x dat_r", 'h123, rd);
        wb_write(vga_pkg::REG_BOSS_Y, 16'h0AB);
        wb_read(vga_pkg::REG_BOSS_Y, rd);
        check("boss_y dat_r", 'h0AB, rd);
        wb_write(vga_pkg::REG_BOSS_HP, 16'd50);
        wb_read(vga_pkg::REG_BOSS_HP, rd);
        check("boss_hp dat_r", 50, rd);
        // above a full bar.
        wb_write(vga_pkg::REG_BOSS_HP, 16'd100);
        wb_read(vga_pkg::REG_BOSS_HP, rd);
        check("boss_hp clipped", vga_pkg::HP_MAX, rd);
        wb_write(vga_pkg::REG_BG, 16'hFABC);
        wb_read(vga_pkg::REG_BG, rd);
        check("bg dat_r", 'hABC, rd);
        wb_write(3'd5, 16'hFFFF);
        wb_read(3'd5, rd);
        check("unused dat_r", 0, rd);
        wb_read(3'd7, rd);
        check("unused dat_r", 0, rd);

        // one whole frame of timing, starting on the pixel after the last one.
        wait_pixel(H_TOTAL - 1, V_TOTAL - 1);
        for (k = 0; k < FRAME; k++) begin
            next_cycle();
            x = k % H_TOTAL;
            y = k / H_TOTAL;
            check("hcount", x, hcount);
            check("vcount", y, vcount);
            check("hsync", (x >= H_SYNC_START) && (x < H_SYNC_END), hsync);
            check("vsync", (y >= V_SYNC_START) && (y < V_SYNC_END), vsync);
            check("blank", (x >= H_ACTIVE) || (y >= V_ACTIVE), blank);
            if (x >= H_ACTIVE || y >= V_ACTIVE) check("blank rgb", 0, rgb);
        end

        // table rows.
        for (r = 0; r < NUM_ROWS; r++) begin
            if (STIM[r][C_BG] == RAND_BG) begin
                draw_bits(12, bits);
                bg = bits[11:0];
            end else begin
                bg = 12'(STIM[r][C_BG]);
            end
            // window centre moves by -1 to +2.
            draw_bits(2, bits);
            cx = STIM[r][C_PX] + int'(bits[1:0]) - 1;
            draw_bits(2, bits);
            cy = STIM[r][C_PY] + int'(bits[1:0]) - 1;
            wb_write(vga_pkg::REG_BG, 16'(bg));
            wb_write(vga_pkg::REG_BOSS_X, 16'(STIM[r][C_BX]));
            wb_write(vga_pkg::REG_BOSS_Y, 16'(STIM[r][C_BY]));
            wb_write(vga_pkg::REG_BOSS_HP, 16'(STIM[r][C_HP]));
            wb_write(vga_pkg::REG_STATE, 16'(STIM[r][C_STATE]));
            // two render stages plus the register edge.
            repeat (3) next_cycle();
            wait_pixel(0, 0);
            for (k = 0; k < V_ACTIVE * H_TOTAL; k++) begin
                x = k % H_TOTAL;
                y = k / H_TOTAL;
                check("boss_alive", STIM[r][C_ALIVE], boss_alive);
                // bar rows whole, plus the window around the probe.
                if ((y >= vga_pkg::BAR_Y0 && y <= vga_pkg::BAR_Y1) ||
                    (x >= cx - WIN && x <= cx + WIN && y >= cy - WIN && y <= cy + WIN)) begin
                    check("rgb", expected_rgb(r, x, y, bg), rgb);
                end
                next_cycle();
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
